/* build.f */
muldiv_pkg.sv
muldiv_ctrl.sv
muldiv_mul.sv
muldiv_div.sv
muldiv_unit.sv
tb_muldiv.sv

/* muldiv_ctrl.sv */
// ---------------------------------------------------------------------------
// muldiv controller
// steers an issued M-extension instruction to the multiplier or divider,
// stalls the pipeline while a unit runs and builds the writeback
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl (
    input  wire                                         clk,
    input  wire                                         arst_n_i,
    input  wire                                         req_valid_i,
    input  wire muldiv_pkg::muldiv_req_t                req_i,
    input  wire                                         int_assert_i,
    input  wire                                         mul_busy_i,
    input  wire                                         mul_ready_i,
    input  wire                                         div_busy_i,
    input  wire                                         div_ready_i,
    input  wire        [muldiv_pkg::XLEN-1:0]           mul_result_i,
    input  wire        [muldiv_pkg::XLEN-1:0]           div_result_i,
    input  wire        [muldiv_pkg::REG_ADDR_W-1:0]     mul_rd_i,
    input  wire        [muldiv_pkg::REG_ADDR_W-1:0]     div_rd_i,
    output logic                                        mul_start_o,
    output logic                                        div_start_o,
    output muldiv_pkg::muldiv_cmd_t                     mul_cmd_o,
    output muldiv_pkg::muldiv_cmd_t                     div_cmd_o,
    output logic                                        hold_o,
    output logic                                        jump_o,
    output muldiv_pkg::muldiv_wb_t                      wb_o
);

    muldiv_pkg::muldiv_cmd_t cmd;
    logic                    req_is_div;
    logic                    launch;
    logic                    launched_q;

    // both units see the same operands, only start differs
    assign cmd.op = req_i.op;
    assign cmd.a  = req_i.rs1;
    assign cmd.b  = req_i.rs2;
    assign cmd.rd = req_i.rd;

    assign mul_cmd_o  = cmd;
    assign div_cmd_o  = cmd;
    assign req_is_div = muldiv_pkg::is_div_op(req_i.op);

    always_comb begin
        mul_start_o = 1'b0;
        div_start_o = 1'b0;
        hold_o      = 1'b0;
        jump_o      = 1'b0;
        wb_o        = '0;
        launch      = 1'b0;

        // an interrupt drops every start, so a busy unit aborts
        if (!int_assert_i) begin
            if (div_busy_i) begin
                div_start_o = 1'b1;
                hold_o      = 1'b1;
            end else if (mul_busy_i) begin
                mul_start_o = 1'b1;
                hold_o      = 1'b1;
            end else if (div_ready_i) begin
                // divider wins if both report at once
                wb_o.we    = 1'b1;
                wb_o.waddr = div_rd_i;
                wb_o.wdata = div_result_i;
            end else if (mul_ready_i) begin
                wb_o.we    = 1'b1;
                wb_o.waddr = mul_rd_i;
                wb_o.wdata = mul_result_i;
            end else if (req_valid_i && !launched_q) begin
                launch = 1'b1;
                jump_o = 1'b1;
                hold_o = 1'b1;
                if (req_is_div) begin
                    div_start_o = 1'b1;
                end else begin
                    mul_start_o = 1'b1;
                end
            end
        end
    end

    // one operation in flight from launch to writeback
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            launched_q <= 1'b0;
        end else if (int_assert_i || mul_ready_i || div_ready_i) begin
            launched_q <= 1'b0;
        end else if (launch) begin
            launched_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* muldiv_div.sv */
// ---------------------------------------------------------------------------
// muldiv divider
// 32-step restoring divider for div, divu, rem and remu, with the
// RISC-V results for a zero divisor and signed overflow
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_div (
    input  wire                                     clk,
    input  wire                                     arst_n_i,
    input  wire                                     start_i,
    input  wire muldiv_pkg::muldiv_cmd_t            cmd_i,
    output logic                                    busy_o,
    output logic                                    ready_o,
    output logic [muldiv_pkg::XLEN-1:0]             result_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0]       rd_o
);

    typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_DONE} div_state_e;

    div_state_e                           state_q;
    logic [4:0]                           cnt_q;
    muldiv_pkg::muldiv_op_e               op_q;
    logic [muldiv_pkg::REG_ADDR_W-1:0]    rd_q;
    logic [muldiv_pkg::XLEN-1:0]          dividend_q;
    logic [muldiv_pkg::XLEN-1:0]          divisor_q;
    logic [muldiv_pkg::XLEN-1:0]          quot_q;
    logic [muldiv_pkg::XLEN-1:0]          rem_q;
    logic                                 q_neg_q;
    logic                                 r_neg_q;
    logic                                 zero_q;
    logic                                 ovf_q;

    logic                                 is_signed;
    logic                                 a_neg;
    logic                                 b_neg;
    logic [muldiv_pkg::XLEN-1:0]          a_mag;
    logic [muldiv_pkg::XLEN-1:0]          b_mag;
    logic [muldiv_pkg::XLEN:0]            shifted;
    logic [muldiv_pkg::XLEN+1:0]          diff;
    logic [muldiv_pkg::XLEN-1:0]          quot_fix;
    logic [muldiv_pkg::XLEN-1:0]          rem_fix;
    logic                                 sel_quot;

    assign is_signed = (cmd_i.op == muldiv_pkg::OP_DIV) || (cmd_i.op == muldiv_pkg::OP_REM);
    assign a_neg     = is_signed & cmd_i.a[muldiv_pkg::XLEN-1];
    assign b_neg     = is_signed & cmd_i.b[muldiv_pkg::XLEN-1];
    assign a_mag     = a_neg ? -cmd_i.a : cmd_i.a;
    assign b_mag     = b_neg ? -cmd_i.b : cmd_i.b;

    // bring down the next dividend bit and try the subtraction
    assign shifted = {rem_q, quot_q[muldiv_pkg::XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_BUSY;
                        cnt_q   <= '0;
                    end
                end
                DIV_BUSY: begin
                    if (!start_i) begin
                        state_q <= DIV_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 5'd1;
                        if (cnt_q == 5'd31) begin
                            state_q <= DIV_DONE;
                        end
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            op_q       <= cmd_i.op;
            rd_q       <= cmd_i.rd;
            dividend_q <= cmd_i.a;
            divisor_q  <= b_mag;
            quot_q     <= a_mag;
            rem_q      <= '0;
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;
            zero_q     <= (cmd_i.b == '0);
            // most negative over minus one
            ovf_q      <= is_signed && (cmd_i.a == {1'b1, {(muldiv_pkg::XLEN-1){1'b0}}}) &&
                          (cmd_i.b == '1);
        end else if (state_q == DIV_BUSY) begin
            if (!diff[muldiv_pkg::XLEN+1]) begin
                rem_q  <= diff[muldiv_pkg::XLEN-1:0];
                quot_q <= {quot_q[muldiv_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[muldiv_pkg::XLEN-1:0];
                quot_q <= {quot_q[muldiv_pkg::XLEN-2:0], 1'b0};
            end
        end
    end

    assign quot_fix = q_neg_q ? -quot_q : quot_q;
    assign rem_fix  = r_neg_q ? -rem_q : rem_q;
    assign sel_quot = (op_q == muldiv_pkg::OP_DIV) || (op_q == muldiv_pkg::OP_DIVU);

    always_comb begin
        if (zero_q) begin
            result_o = sel_quot ? '1 : dividend_q;
        end else if (ovf_q) begin
            result_o = sel_quot ? dividend_q : '0;
        end else begin
            result_o = sel_quot ? quot_fix : rem_fix;
        end
    end

    assign busy_o  = (state_q == DIV_BUSY);
    assign ready_o = (state_q == DIV_DONE);
    assign rd_o    = rd_q;

endmodule

`default_nettype wire

/* muldiv_mul.sv */
// ---------------------------------------------------------------------------
// muldiv multiplier
// serial shift-add multiplier for mul, mulh, mulhsu and mulhu,
// one partial product per cycle over 32 cycles
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_mul (
    input  wire                                     clk,
    input  wire                                     arst_n_i,
    input  wire                                     start_i,
    input  wire muldiv_pkg::muldiv_cmd_t            cmd_i,
    output logic                                    busy_o,
    output logic                                    ready_o,
    output logic [muldiv_pkg::XLEN-1:0]             result_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0]       rd_o
);

    typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_e;

    mul_state_e                           state_q;
    logic [4:0]                           cnt_q;
    muldiv_pkg::muldiv_op_e               op_q;
    logic [muldiv_pkg::REG_ADDR_W-1:0]    rd_q;
    logic [muldiv_pkg::XLEN-1:0]          mcand_q;
    logic [2*muldiv_pkg::XLEN-1:0]        prod_q;
    logic                                 neg_q;

    logic                                 a_signed;
    logic                                 b_signed;
    logic [muldiv_pkg::XLEN-1:0]          a_mag;
    logic [muldiv_pkg::XLEN-1:0]          b_mag;
    logic [muldiv_pkg::XLEN:0]            part_sum;
    logic [2*muldiv_pkg::XLEN-1:0]        prod_fix;

    // mul keeps the low word, so unsigned magnitudes are fine there
    assign a_signed = (cmd_i.op == muldiv_pkg::OP_MULH) || (cmd_i.op == muldiv_pkg::OP_MULHSU);
    assign b_signed = (cmd_i.op == muldiv_pkg::OP_MULH);
    assign a_mag    = (a_signed && cmd_i.a[muldiv_pkg::XLEN-1]) ? -cmd_i.a : cmd_i.a;
    assign b_mag    = (b_signed && cmd_i.b[muldiv_pkg::XLEN-1]) ? -cmd_i.b : cmd_i.b;

    // upper half plus multiplicand when the current multiplier bit is set
    assign part_sum = prod_q[0] ?
        {1'b0, prod_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]} + {1'b0, mcand_q} :
        {1'b0, prod_q[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_BUSY;
                        cnt_q   <= '0;
                    end
                end
                MUL_BUSY: begin
                    // start dropped by the controller means abort
                    if (!start_i) begin
                        state_q <= MUL_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 5'd1;
                        if (cnt_q == 5'd31) begin
                            state_q <= MUL_DONE;
                        end
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MUL_IDLE && start_i) begin
            op_q    <= cmd_i.op;
            rd_q    <= cmd_i.rd;
            mcand_q <= a_mag;
            prod_q  <= {{muldiv_pkg::XLEN{1'b0}}, b_mag};
            neg_q   <= (a_signed & cmd_i.a[muldiv_pkg::XLEN-1]) ^
                       (b_signed & cmd_i.b[muldiv_pkg::XLEN-1]);
        end else if (state_q == MUL_BUSY) begin
            prod_q <= {part_sum, prod_q[muldiv_pkg::XLEN-1:1]};
        end
    end

    assign prod_fix = neg_q ? -prod_q : prod_q;
    assign result_o = (op_q == muldiv_pkg::OP_MUL) ? prod_fix[muldiv_pkg::XLEN-1:0] :
                      prod_fix[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN];
    assign busy_o   = (state_q == MUL_BUSY);
    assign ready_o  = (state_q == MUL_DONE);
    assign rd_o     = rd_q;

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
// ---------------------------------------------------------------------------
// muldiv package
// opcode encoding, widths and bus structs shared by the RV32M
// multiply/divide block
// ---------------------------------------------------------------------------
`default_nettype none

package muldiv_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // follows the funct3 field of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    // issued instruction from dispatch
    typedef struct packed {
        muldiv_op_e            op;
        logic [XLEN-1:0]       rs1;
        logic [XLEN-1:0]       rs2;
        logic [REG_ADDR_W-1:0] rd;
    } muldiv_req_t;

    // command to the multiplier or the divider
    typedef struct packed {
        muldiv_op_e            op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
    } muldiv_cmd_t;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } muldiv_wb_t;

    // div, divu, rem and remu
    function automatic logic is_div_op(muldiv_op_e op);
        return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

`default_nettype wire

/* muldiv_unit.sv */
// ---------------------------------------------------------------------------
// muldiv unit
// RV32M execution block, controller plus serial multiplier and divider
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  wire                             clk,
    input  wire                             arst_n_i,
    input  wire                             req_valid_i,
    input  wire muldiv_pkg::muldiv_req_t    req_i,
    input  wire                             int_assert_i,
    output logic                            hold_o,
    output logic                            jump_o,
    output muldiv_pkg::muldiv_wb_t          wb_o
);

    logic                                 mul_start;
    logic                                 div_start;
    muldiv_pkg::muldiv_cmd_t              mul_cmd;
    muldiv_pkg::muldiv_cmd_t              div_cmd;
    logic                                 mul_busy;
    logic                                 mul_ready;
    logic                                 div_busy;
    logic                                 div_ready;
    logic [muldiv_pkg::XLEN-1:0]          mul_result;
    logic [muldiv_pkg::XLEN-1:0]          div_result;
    logic [muldiv_pkg::REG_ADDR_W-1:0]    mul_rd;
    logic [muldiv_pkg::REG_ADDR_W-1:0]    div_rd;

    muldiv_ctrl ctrl0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .mul_busy_i   (mul_busy),
        .mul_ready_i  (mul_ready),
        .div_busy_i   (div_busy),
        .div_ready_i  (div_ready),
        .mul_result_i (mul_result),
        .div_result_i (div_result),
        .mul_rd_i     (mul_rd),
        .div_rd_i     (div_rd),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start),
        .mul_cmd_o    (mul_cmd),
        .div_cmd_o    (div_cmd),
        .hold_o       (hold_o),
        .jump_o       (jump_o),
        .wb_o         (wb_o)
    );

    muldiv_mul mul0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mul_start),
        .cmd_i    (mul_cmd),
        .busy_o   (mul_busy),
        .ready_o  (mul_ready),
        .result_o (mul_result),
        .rd_o     (mul_rd)
    );

    muldiv_div div0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (div_start),
        .cmd_i    (div_cmd),
        .busy_o   (div_busy),
        .ready_o  (div_ready),
        .result_o (div_result),
        .rd_o     (div_rd)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the muldiv testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_muldiv \
    -f build.f -o sim_muldiv \
    && ./obj_dir/sim_muldiv > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^all tests passed$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

/* tb_muldiv.sv */
// ---------------------------------------------------------------------------
// muldiv testbench
// self-checking testbench for the RV32M multiply/divide block, with a
// reference model, random and corner stimulus, interrupt abort and timing
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv;

    localparam int CLK_PERIOD = 4;
    // mul 4x56, div 4x40, special cases, aborts with re-issue, back-to-back
    localparam int N_OPS      = 4 * 56 + 4 * 40 + 8 + 4 + 16;

    logic                    clk;
    logic                    arst_n;
    logic                    req_valid;
    muldiv_pkg::muldiv_req_t req;
    logic                    int_assert;
    logic                    hold;
    logic                    jump;
    muldiv_pkg::muldiv_wb_t  wb;

    logic [31:0] seed;
    logic [31:0] corner [0:3];
    logic [31:0] exp_data_q [$];
    logic [4:0]  exp_rd_q [$];
    string       name_q [$];
    string       cur_name;
    logic        in_flight;
    int          age;
    int          wb_checks;
    int          val_err;
    int          other_err;
    int          drv_err;

    muldiv_unit dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .int_assert_i (int_assert),
        .hold_o       (hold),
        .jump_o       (jump),
        .wb_o         (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RISC-V M-extension result from 64-bit arithmetic
    function automatic logic [31:0] ref_muldiv(input muldiv_pkg::muldiv_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'd0, a};
        ub  = {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        p   = '0;
        case (op)
            muldiv_pkg::OP_MUL:    p = ua * ub;
            muldiv_pkg::OP_MULH:   p = (sa * sb) >> 32;
            muldiv_pkg::OP_MULHSU: p = (sa * $signed(ub)) >> 32;
            muldiv_pkg::OP_MULHU:  p = (ua * ub) >> 32;
            muldiv_pkg::OP_DIV: begin
                if (b == 32'd0)
                    p = '1;
                else if (ovf)
                    p = ua;
                else
                    p = sa / sb;
            end
            muldiv_pkg::OP_DIVU: begin
                if (b == 32'd0)
                    p = '1;
                else
                    p = ua / ub;
            end
            muldiv_pkg::OP_REM: begin
                if (b == 32'd0)
                    p = ua;
                else if (ovf)
                    p = '0;
                else
                    p = sa % sb;
            end
            default: begin
                if (b == 32'd0)
                    p = ua;
                else
                    p = ua % ub;
            end
        endcase
        return p[31:0];
    endfunction

    task automatic drive_req(input muldiv_pkg::muldiv_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic [4:0] rd);
        @(posedge clk);
        req_valid <= 1'b1;
        req.op    <= op;
        req.rs1   <= a;
        req.rs2   <= b;
        req.rd    <= rd;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    // issue one request and wait for its writeback
    task automatic run_op(input string name, input muldiv_pkg::muldiv_op_e op,
                          input logic [31:0] a, input logic [31:0] b, input logic [4:0] rd);
        int waited;
        waited   = 0;
        cur_name = name;
        exp_data_q.push_back(ref_muldiv(op, a, b));
        exp_rd_q.push_back(rd);
        name_q.push_back(name);
        drive_req(op, a, b, rd);
        do begin
            @(negedge clk);
            waited++;
        end while (!wb.we && waited < 40);
        assert (wb.we) else begin
            drv_err++;
            $display("%s gave no writeback within 40 cycles", name);
        end
    endtask

    // launch, interrupt for two cycles at cycle mid, then issue again
    task automatic run_abort(input string name, input muldiv_pkg::muldiv_op_e op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] rd, input int mid);
        cur_name = name;
        drive_req(op, a, b, rd);
        repeat (mid) @(posedge clk);
        int_assert <= 1'b1;
        req_valid  <= 1'b0;
        repeat (2) @(posedge clk);
        int_assert <= 1'b0;
        idle_cycles(40);
        run_op(name, op, a, b, rd);
    endtask

    task automatic compare_wb();
        logic [31:0] exp_data;
        logic [4:0]  exp_rd;
        string       exp_name;
        assert (exp_data_q.size() != 0) else begin
            other_err++;
            $display("write to x%0d with no issued request outstanding", wb.waddr);
        end
        if (exp_data_q.size() != 0) begin
            exp_data = exp_data_q.pop_front();
            exp_rd   = exp_rd_q.pop_front();
            exp_name = name_q.pop_front();
            wb_checks++;
            assert (wb.wdata == exp_data) else begin
                val_err++;
                $display("ERR %s data: expected %h actual %h", exp_name, exp_data, wb.wdata);
            end
            assert (wb.waddr == exp_rd) else begin
                val_err++;
                $display("ERR %s rd: expected %0d actual %0d", exp_name, exp_rd, wb.waddr);
            end
        end
    endtask

    // per-cycle protocol and result checks at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (int_assert) begin
                assert (!hold && !jump && !wb.we) else begin
                    other_err++;
                    $display("hold, jump or write enable high during an interrupt");
                end
                in_flight = 1'b0;
            end else if (in_flight) begin
                age++;
                assert (!jump) else begin
                    other_err++;
                    $display("jump high %0d cycles after launch", age);
                end
                assert (hold == (age < 33)) else begin
                    other_err++;
                    $display("hold at %b %0d cycles after launch", hold, age);
                end
                if (wb.we) begin
                    assert (age == 33) else begin
                        val_err++;
                        $display("ERR %s latency: expected 33 actual %0d", cur_name, age);
                    end
                end
                if (age == 33) begin
                    assert (wb.we) else begin
                        other_err++;
                        $display("no write enable 33 cycles after launch");
                    end
                    in_flight = 1'b0;
                end
            end else begin
                assert (!wb.we) else begin
                    other_err++;
                    $display("write enable with no operation in flight");
                end
                // a new request must launch in its first cycle
                assert (jump == req_valid) else begin
                    other_err++;
                    $display("jump at %b with request valid at %b and the unit idle",
                             jump, req_valid);
                end
                if (jump) begin
                    assert (hold) else begin
                        other_err++;
                        $display("hold low in the launch cycle");
                    end
                    in_flight = 1'b1;
                    age       = 0;
                end else begin
                    assert (!hold) else begin
                        other_err++;
                        $display("hold high with no operation in flight");
                    end
                end
            end
            if (wb.we) begin
                compare_wb();
            end
        end
    end

    initial begin
        #(N_OPS * 40 * CLK_PERIOD + 2000);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        muldiv_pkg::muldiv_op_e op;
        logic [31:0]            a;
        logic [31:0]            b;
        int                     k;
        int                     i;
        int                     j;
        clk        = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        int_assert = 1'b0;
        seed       = 32'h4bf7_2fcd;
        in_flight  = 1'b0;
        age        = 0;
        wb_checks  = 0;
        val_err    = 0;
        other_err  = 0;
        drv_err    = 0;
        cur_name   = "none";
        corner[0]  = 32'h0000_0000;
        corner[1]  = 32'h0000_0001;
        corner[2]  = 32'hffff_ffff;
        corner[3]  = 32'h8000_0000;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        idle_cycles(2);

        // multiply ops over random and corner operands
        for (k = 0; k < 4; k++) begin
            op = muldiv_pkg::muldiv_op_e'(3'(k));
            for (i = 0; i < 40; i++) begin
                seed = lcg_next(seed);
                a    = seed;
                seed = lcg_next(seed);
                b    = seed;
                run_op($sformatf("mul_rand %s", op.name()), op, a, b, seed[31:27]);
                idle_cycles(1);
            end
            for (i = 0; i < 4; i++) begin
                for (j = 0; j < 4; j++) begin
                    run_op($sformatf("mul_corner %s", op.name()), op, corner[i], corner[j],
                           5'(i * 4 + j + 1));
                    idle_cycles(1);
                end
            end
        end

        // divide ops with small signed divisors on odd steps
        for (k = 4; k < 8; k++) begin
            op = muldiv_pkg::muldiv_op_e'(3'(k));
            for (i = 0; i < 40; i++) begin
                seed = lcg_next(seed);
                a    = seed;
                seed = lcg_next(seed);
                b    = i[0] ? {{24{seed[31]}}, seed[7:0]} : seed;
                run_op($sformatf("div_rand %s", op.name()), op, a, b, seed[31:27]);
                idle_cycles(1);
            end
        end

        // zero divisor and signed overflow
        for (k = 4; k < 8; k++) begin
            op   = muldiv_pkg::muldiv_op_e'(3'(k));
            seed = lcg_next(seed);
            run_op($sformatf("div_zero %s", op.name()), op, seed, 32'd0, 5'd7);
            idle_cycles(1);
            run_op($sformatf("div_ovf %s", op.name()), op, 32'h8000_0000, 32'hffff_ffff,
                   5'd9);
            idle_cycles(1);
        end

        run_abort("int_abort MULH", muldiv_pkg::OP_MULH, 32'hdead_beef, 32'h1234_5678,
                  5'd3, 12);
        idle_cycles(1);
        run_abort("int_abort DIV", muldiv_pkg::OP_DIV, 32'hf000_0001, 32'h0000_0123,
                  5'd4, 20);
        idle_cycles(1);

        // back to back requests alternating multiply and divide
        for (i = 0; i < 16; i++) begin
            seed = lcg_next(seed);
            op   = muldiv_pkg::muldiv_op_e'({i[0], seed[1:0]});
            a    = seed;
            seed = lcg_next(seed);
            b    = seed;
            run_op($sformatf("b2b %s", op.name()), op, a, b, seed[31:27]);
        end
        idle_cycles(3);

        assert (exp_data_q.size() == 0) else begin
            drv_err++;
            $display("%0d issued operations never wrote back", exp_data_q.size());
        end
        $display("summary: %0d checked, %0d value errors, %0d protocol errors, %0d timeouts",
                 wb_checks, val_err, other_err, drv_err);
        if (val_err + other_err + drv_err == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
